// ==== src/uart_pkg.sv ====
package uart_pkg;

  localparam int CMD_W  = 16;
  localparam int BYTE_W = 8;
  localparam int DIV_W  = 16;
  localparam int FMT_W  = 3;

  // longest frame: start, 8 data, parity, 2 stop
  localparam int FRAME_MAX_BITS = 12;

  typedef logic [CMD_W-1:0]  cmd_t;
  typedef logic [BYTE_W-1:0] byte_t;
  typedef logic [DIV_W-1:0]  div_t;
  typedef logic              cfg_addr_t;

  // write flag, sent as the msb of the address byte
  localparam int CMD_WR_BIT = CMD_W - 1;

  // configuration register map
  localparam cfg_addr_t CFG_DIV_ADDR = 1'b0;
  localparam cfg_addr_t CFG_FMT_ADDR = 1'b1;

  // format register bits
  localparam int FMT_PAR_EN_BIT   = 0;
  localparam int FMT_PAR_ODD_BIT  = 1;
  localparam int FMT_TWO_STOP_BIT = 2;

  // 115200 baud at 50 MHz
  localparam div_t DEFAULT_DIV = 16'd434;
  localparam div_t MIN_DIV     = 16'd4;

  // odd parity, one stop bit
  localparam logic [FMT_W-1:0] DEFAULT_FMT = 3'b011;

endpackage

// ==== src/uart_cfg_if.sv ====
`timescale 1ns/1ns

interface uart_cfg_if import uart_pkg::*; ();

  div_t div;
  logic parity_en;
  logic parity_odd;
  logic two_stop;

  modport src (
    output div, parity_en, parity_odd, two_stop
  );

  modport snk (
    input div, parity_en, parity_odd, two_stop
  );

endinterface

// ==== src/rx_frame_if.sv ====
`timescale 1ns/1ns

interface rx_frame_if import uart_pkg::*; ();

  logic  vld;
  byte_t data;
  logic  parity_err;
  logic  stop_err;

  modport src (
    output vld, data, parity_err, stop_err
  );

  modport snk (
    input vld, data, parity_err, stop_err
  );

endinterface

// ==== src/uart_cfg_regs.sv ====
`timescale 1ns/1ns

module uart_cfg_regs import uart_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cfg_wr,
  input  cfg_addr_t cfg_addr,
  input  div_t      cfg_wdata,
  output div_t      cfg_rdata,
  uart_cfg_if.src   cfg
);

  div_t             div_q;
  logic [FMT_W-1:0] fmt_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_q <= DEFAULT_DIV;
      fmt_q <= DEFAULT_FMT;
    end else if (cfg_wr) begin
      case (cfg_addr)
        // too short a period is stored as the minimum
        CFG_DIV_ADDR: div_q <= (cfg_wdata < MIN_DIV) ? MIN_DIV : cfg_wdata;
        CFG_FMT_ADDR: fmt_q <= cfg_wdata[FMT_W-1:0];
      endcase
    end
  end

  always_comb begin
    cfg_rdata = '0;
    case (cfg_addr)
      CFG_DIV_ADDR: cfg_rdata = div_q;
      CFG_FMT_ADDR: cfg_rdata = div_t'(fmt_q);
    endcase
  end

  assign cfg.div        = div_q;
  assign cfg.parity_en  = fmt_q[FMT_PAR_EN_BIT];
  assign cfg.parity_odd = fmt_q[FMT_PAR_ODD_BIT];
  assign cfg.two_stop   = fmt_q[FMT_TWO_STOP_BIT];

endmodule

// ==== src/uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx import uart_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    tx_req,
  input  byte_t   tx_byte,
  output logic    tx_busy,
  output logic    tx,
  uart_cfg_if.snk cfg
);

  logic [FRAME_MAX_BITS-1:0] frame_d;
  logic [FRAME_MAX_BITS-1:0] shift_q;
  div_t                      div_q;
  div_t                      cnt_q;
  logic [3:0]                bit_idx_q;
  logic [3:0]                last_idx_q;
  logic                      parity_bit;
  logic                      start;
  logic                      bit_end;

  // even parity, inverted for odd
  assign parity_bit = (^tx_byte) ^ cfg.parity_odd;

  always_comb begin
    frame_d      = '1;
    frame_d[0]   = 1'b0;
    frame_d[8:1] = tx_byte;
    if (cfg.parity_en) begin
      frame_d[9] = parity_bit;
    end
  end

  assign start   = tx_req && !tx_busy;
  assign bit_end = (cnt_q == div_q - div_t'(1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_busy    <= 1'b0;
      tx         <= 1'b1;
      cnt_q      <= '0;
      bit_idx_q  <= '0;
      last_idx_q <= '0;
    end else if (start) begin
      tx_busy    <= 1'b1;
      tx         <= 1'b0;
      cnt_q      <= '0;
      bit_idx_q  <= '0;
      last_idx_q <= 4'd9 + {3'b000, cfg.parity_en} + {3'b000, cfg.two_stop};
    end else if (tx_busy) begin
      if (bit_end) begin
        cnt_q <= '0;
        if (bit_idx_q == last_idx_q) begin
          // last stop period done, back to idle
          tx_busy <= 1'b0;
          tx      <= 1'b1;
        end else begin
          bit_idx_q <= bit_idx_q + 4'd1;
          tx        <= shift_q[1];
        end
      end else begin
        cnt_q <= cnt_q + div_t'(1);
      end
    end
  end

  // frame and period held for the whole frame
  always_ff @(posedge clk) begin
    if (start) begin
      shift_q <= frame_d;
      div_q   <= cfg.div;
    end else if (tx_busy && bit_end) begin
      shift_q <= {1'b1, shift_q[FRAME_MAX_BITS-1:1]};
    end
  end

endmodule

// ==== src/uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx import uart_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    rx,
  rx_frame_if.src frame,
  uart_cfg_if.snk cfg
);

  logic       rx_meta;
  logic       rx_sync;
  logic       rx_prev;
  logic       busy_q;
  div_t       cnt_q;
  logic [3:0] bit_idx_q;
  byte_t      data_q;
  logic       par_err_q;
  logic       stop_err_q;
  logic       vld_q;
  logic       start_edge;
  logic       mid_bit;
  logic       bit_end;
  logic       in_data;
  logic [3:0] stop_idx;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign start_edge = rx_prev && !rx_sync && !busy_q;
  assign mid_bit    = (cnt_q == (cfg.div >> 1));
  assign bit_end    = (cnt_q == cfg.div - div_t'(1));
  assign in_data    = (bit_idx_q >= 4'd1) && (bit_idx_q <= 4'd8);
  // only the first stop bit is checked
  assign stop_idx   = cfg.parity_en ? 4'd10 : 4'd9;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      vld_q     <= 1'b0;
    end else begin
      vld_q <= 1'b0;
      if (start_edge) begin
        busy_q    <= 1'b1;
        cnt_q     <= '0;
        bit_idx_q <= '0;
      end else if (busy_q) begin
        if (bit_end) begin
          cnt_q     <= '0;
          bit_idx_q <= bit_idx_q + 4'd1;
        end else begin
          cnt_q <= cnt_q + div_t'(1);
        end
        if (mid_bit) begin
          if (bit_idx_q == 4'd0 && rx_sync) begin
            // glitch, start bit not low at mid-period
            busy_q <= 1'b0;
          end else if (bit_idx_q == stop_idx) begin
            busy_q <= 1'b0;
            vld_q  <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_edge) begin
      par_err_q <= 1'b0;
    end else if (busy_q && mid_bit) begin
      if (in_data) begin
        data_q <= {rx_sync, data_q[BYTE_W-1:1]};
      end else if (cfg.parity_en && bit_idx_q == 4'd9) begin
        par_err_q <= rx_sync ^ (^data_q) ^ cfg.parity_odd;
      end else if (bit_idx_q == stop_idx) begin
        stop_err_q <= !rx_sync;
      end
    end
  end

  assign frame.vld        = vld_q;
  assign frame.data       = data_q;
  assign frame.parity_err = par_err_q;
  assign frame.stop_err   = stop_err_q;

endmodule

// ==== src/uart_cmd_ctrl.sv ====
`timescale 1ns/1ns

module uart_cmd_ctrl import uart_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    cmd_vld,
  input  cmd_t    cmd_in,
  input  logic    tx_busy,
  output logic    cmd_rdy,
  output logic    tx_req,
  output byte_t   tx_byte,
  output logic    read_vld,
  output byte_t   read_data,
  output logic    read_err,
  rx_frame_if.snk frame
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA,
    ST_WR_WAIT,
    ST_RD_TX,
    ST_RD_RSP
  } state_t;

  state_t state_q;
  cmd_t   cmd_q;
  logic   is_write;

  assign is_write = cmd_q[CMD_WR_BIT];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= ST_IDLE;
      read_vld <= 1'b0;
      read_err <= 1'b0;
    end else begin
      read_vld <= 1'b0;
      case (state_q)
        ST_IDLE: if (cmd_vld) state_q <= ST_ADDR;
        ST_ADDR: begin
          if (!tx_busy) begin
            state_q <= is_write ? ST_DATA : ST_RD_TX;
          end
        end
        ST_DATA: if (!tx_busy) state_q <= ST_WR_WAIT;
        ST_WR_WAIT: if (!tx_busy) state_q <= ST_IDLE;
        // frames seen while the address is still going out are dropped
        ST_RD_TX: if (!tx_busy) state_q <= ST_RD_RSP;
        ST_RD_RSP: begin
          if (frame.vld) begin
            state_q  <= ST_IDLE;
            read_vld <= 1'b1;
            read_err <= frame.parity_err || frame.stop_err;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && cmd_vld) begin
      cmd_q <= cmd_in;
    end
    if (state_q == ST_RD_RSP && frame.vld) begin
      read_data <= frame.data;
    end
  end

  assign cmd_rdy = (state_q == ST_IDLE);
  assign tx_req  = (state_q == ST_ADDR) || (state_q == ST_DATA);
  // address byte carries the write flag in its msb
  assign tx_byte = (state_q == ST_DATA) ? cmd_q[BYTE_W-1:0] : cmd_q[CMD_W-1:BYTE_W];

endmodule

// ==== src/uart_bridge_top.sv ====
`timescale 1ns/1ns

module uart_bridge_top import uart_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cmd_vld,
  input  cmd_t      cmd_in,
  input  logic      cfg_wr,
  input  cfg_addr_t cfg_addr,
  input  div_t      cfg_wdata,
  input  logic      rx,
  output logic      cmd_rdy,
  output logic      read_vld,
  output byte_t     read_data,
  output logic      read_err,
  output div_t      cfg_rdata,
  output logic      tx
);

  logic  tx_req;
  byte_t tx_byte;
  logic  tx_busy;

  uart_cfg_if cfg_if ();
  rx_frame_if rx_if ();

  uart_cfg_regs u_cfg_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .cfg       (cfg_if.src)
  );

  uart_tx u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_req  (tx_req),
    .tx_byte (tx_byte),
    .tx_busy (tx_busy),
    .tx      (tx),
    .cfg     (cfg_if.snk)
  );

  uart_rx u_rx (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .frame (rx_if.src),
    .cfg   (cfg_if.snk)
  );

  uart_cmd_ctrl u_cmd_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_vld   (cmd_vld),
    .cmd_in    (cmd_in),
    .tx_busy   (tx_busy),
    .cmd_rdy   (cmd_rdy),
    .tx_req    (tx_req),
    .tx_byte   (tx_byte),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_err  (read_err),
    .frame     (rx_if.snk)
  );

endmodule

// ==== bench/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD = 2;
  localparam int RESET_CYCLES = 10;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

// ==== bench/uart_bridge_sva.sv ====
`timescale 1ns/1ns

module uart_bridge_sva (
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic read_vld,
  input logic tx
);

  // line idles while the bridge is ready
  idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy && $past(cmd_rdy) |-> tx)
    else $error("tx low while bridge idle");

  read_vld_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |=> !read_vld)
    else $error("read_vld held for two cycles");

  rdy_drops_on_accept: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_vld && cmd_rdy |=> !cmd_rdy)
    else $error("cmd_rdy high after accepted command");

endmodule

bind uart_bridge_top uart_bridge_sva u_sva (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .read_vld (read_vld),
  .tx       (tx)
);

// ==== bench/tb_uart_bridge.sv ====
`timescale 1ns/1ns

module tb_uart_bridge import uart_pkg::*; ();

  localparam int CLK_PERIOD = 4;
  localparam int NUM_FMTS = 6;
  localparam int NUM_CMDS = NUM_FMTS * 24 + 20;
  localparam int MAX_DIV = 25;

  logic clk;
  logic rst_n;
  logic cmd_vld;
  cmd_t cmd_in;
  logic cfg_wr;
  cfg_addr_t cfg_addr;
  div_t cfg_wdata;
  logic rx;
  logic cmd_rdy;
  logic read_vld;
  byte_t read_data;
  logic read_err;
  div_t cfg_rdata;
  logic tx;

  logic [31:0] lfsr_q = 32'h9bc8fecd;
  int cur_div;
  logic [FMT_W-1:0] cur_fmt;
  logic inject_errs;
  byte_t mem [128];
  byte_t exp_bytes [$];
  byte_t rsp_data [$];
  logic rsp_err [$];
  logic [FMT_W-1:0] fmts [NUM_FMTS] = '{3'b000, 3'b011, 3'b001, 3'b100, 3'b111, 3'b101};

  tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

  uart_bridge_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_vld   (cmd_vld),
    .cmd_in    (cmd_in),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .rx        (rx),
    .cmd_rdy   (cmd_rdy),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_err  (read_err),
    .cfg_rdata (cfg_rdata),
    .tx        (tx)
  );

  // taps 32, 22, 2, 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_byte(input byte_t got, input byte_t exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %b expected %b", $time, what, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_div(input div_t got, input div_t exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %0d expected %0d", $time, what, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic write_cfg(input cfg_addr_t a, input div_t d);
    cfg_addr = a;
    cfg_wdata = d;
    cfg_wr = 1'b1;
    @(posedge clk);
    #1 cfg_wr = 1'b0;
  endtask

  task automatic read_cfg(input cfg_addr_t a, input div_t exp);
    cfg_addr = a;
    @(negedge clk);
    check_div(cfg_rdata, exp, "config read-back");
    @(posedge clk);
    #1;
  endtask

  task automatic set_format(input logic [FMT_W-1:0] fmt);
    cur_fmt = fmt;
    cur_div = 10 + int'(rand_bits(4));
    write_cfg(CFG_DIV_ADDR, div_t'(cur_div));
    write_cfg(CFG_FMT_ADDR, div_t'(fmt));
  endtask

  // starts and ends on a falling clock edge
  task automatic run_cmd(input cmd_t c, input logic hold, input cmd_t next);
    exp_bytes.push_back(c[CMD_W-1:BYTE_W]);
    if (c[CMD_WR_BIT]) exp_bytes.push_back(c[BYTE_W-1:0]);
    if (!cmd_vld) begin
      @(posedge clk);
      #1;
      cmd_vld = 1'b1;
      cmd_in = c;
      @(negedge clk);
    end
    while (!cmd_rdy) @(negedge clk);
    @(posedge clk);
    #1;
    if (hold) cmd_in = next;
    else cmd_vld = 1'b0;
    if (c[CMD_WR_BIT]) begin
      do @(negedge clk); while (!cmd_rdy);
    end else begin
      do @(negedge clk); while (!read_vld);
      if (rsp_data.size() == 0) stop_on_error("read result with no response sent");
      check_byte(read_data, rsp_data.pop_front(), "read data");
      check_err(read_err, rsp_err.pop_front(), "read error flag");
      check_err(cmd_rdy, 1'b1, "cmd_rdy after read");
    end
  endtask

  function automatic cmd_t rand_cmd(input logic wr);
    logic [6:0] a;
    byte_t d;
    a = 7'(rand_bits(7));
    d = byte_t'(rand_bits(8));
    return {wr, a, d};
  endfunction

  // peer side, samples tx on falling edges at mid-bit
  task automatic recv_frame(output byte_t b);
    int d;
    do @(negedge clk); while (tx !== 1'b0);
    if (exp_bytes.size() == 0) stop_on_error("frame on tx with no command pending");
    check_err(cmd_rdy, 1'b0, "cmd_rdy at frame start");
    // period of the command that owns this frame
    d = cur_div;
    repeat (d / 2) @(negedge clk);
    check_err(tx, 1'b0, "start bit");
    for (int i = 0; i < BYTE_W; i++) begin
      repeat (d) @(negedge clk);
      b[i] = tx;
    end
    if (cur_fmt[FMT_PAR_EN_BIT]) begin
      repeat (d) @(negedge clk);
      check_err(tx, (^b) ^ cur_fmt[FMT_PAR_ODD_BIT], "parity bit");
    end
    repeat (d) @(negedge clk);
    check_err(tx, 1'b1, "stop bit");
    if (cur_fmt[FMT_TWO_STOP_BIT]) begin
      repeat (d) @(negedge clk);
      check_err(tx, 1'b1, "second stop bit");
    end
    repeat (d - d / 2 - 1) @(negedge clk);
  endtask

  task automatic drive_frame(input logic [FRAME_MAX_BITS-1:0] bits, input int n, input int d);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #1 rx = bits[i];
      repeat (d - 1) @(posedge clk);
    end
    @(posedge clk);
    #1 rx = 1'b1;
  endtask

  task automatic send_response(input byte_t v);
    logic [FRAME_MAX_BITS-1:0] bits;
    logic [1:0] kind;
    int n;
    int d;
    d = cur_div;
    kind = inject_errs ? 2'(rand_bits(2)) : 2'd0;
    repeat (2 + d * int'(rand_bits(2))) @(posedge clk);
    bits = '1;
    bits[0] = 1'b0;
    bits[8:1] = v;
    n = 9;
    if (cur_fmt[FMT_PAR_EN_BIT]) begin
      bits[9] = (^v) ^ cur_fmt[FMT_PAR_ODD_BIT] ^ (kind == 2'd1);
      n = 10;
    end
    if (kind == 2'd2) bits[n] = 1'b0;
    n = n + 1 + int'(cur_fmt[FMT_TWO_STOP_BIT]);
    rsp_data.push_back(v);
    rsp_err.push_back(kind == 2'd2 || (kind == 2'd1 && cur_fmt[FMT_PAR_EN_BIT]));
    fork
      drive_frame(bits, n, d);
    join_none
  endtask

  initial begin : peer
    byte_t addr;
    byte_t data;
    for (int i = 0; i < 128; i++) mem[i] = byte_t'(i * 37) ^ 8'h5a;
    wait (rst_n);
    forever begin
      recv_frame(addr);
      check_byte(addr, exp_bytes.pop_front(), "address byte");
      if (addr[7]) begin
        recv_frame(data);
        check_byte(data, exp_bytes.pop_front(), "data byte");
        mem[addr[6:0]] = data;
      end else begin
        send_response(mem[addr[6:0]]);
      end
    end
  end

  initial begin : watchdog
    #(longint'(NUM_CMDS) * 40 * FRAME_MAX_BITS * MAX_DIV * CLK_PERIOD + 100000);
    $display("Timeout: the run hung before all commands completed");
    $display("Test failed");
    $fatal(1);
  end

  initial begin : main
    div_t v;
    cmd_t c;
    cmd_t next;
    cmd_vld = 1'b0;
    cmd_in = '0;
    cfg_wr = 1'b0;
    cfg_addr = CFG_DIV_ADDR;
    cfg_wdata = '0;
    rx = 1'b1;
    inject_errs = 1'b0;
    cur_div = int'(DEFAULT_DIV);
    cur_fmt = DEFAULT_FMT;
    wait (rst_n);
    @(posedge clk);
    #1;
    check_err(tx, 1'b1, "tx idle after reset");
    check_err(cmd_rdy, 1'b1, "cmd_rdy after reset");
    check_err(read_vld, 1'b0, "read_vld after reset");
    check_err(read_err, 1'b0, "read_err after reset");
    // 434 cycles per bit, odd parity, one stop bit
    read_cfg(CFG_DIV_ADDR, 16'd434);
    read_cfg(CFG_FMT_ADDR, 16'h0003);

    repeat (16) begin
      v = div_t'(rand_bits(16));
      // short periods exercise the clamp
      if (v[15]) v = v & 16'h0007;
      write_cfg(CFG_DIV_ADDR, v);
      read_cfg(CFG_DIV_ADDR, (v < 16'd4) ? 16'd4 : v);
      v = div_t'(rand_bits(16));
      write_cfg(CFG_FMT_ADDR, v);
      read_cfg(CFG_FMT_ADDR, v & 16'h0007);
    end

    for (int f = 0; f < NUM_FMTS; f++) begin
      set_format(fmts[f]);
      inject_errs = 1'b0;
      repeat (10) run_cmd(rand_cmd(1'b1), 1'b0, '0);
      repeat (10) run_cmd(rand_cmd(1'b0), 1'b0, '0);
      inject_errs = 1'b1;
      repeat (4) run_cmd(rand_cmd(1'b0), 1'b0, '0);
      @(posedge clk);
      #1;
    end

    // cmd_vld held high across completions
    inject_errs = 1'b0;
    set_format(3'b011);
    next = rand_cmd(1'(rand_bits(1)));
    for (int i = 0; i < 20; i++) begin
      c = next;
      next = rand_cmd(1'(rand_bits(1)));
      run_cmd(c, i < 19, next);
    end

    repeat (20 * MAX_DIV) @(posedge clk);
    if (exp_bytes.size() != 0) begin
      stop_on_error("expected frames never seen on tx");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

// ==== sources.f ====
src/uart_pkg.sv
src/uart_cfg_if.sv
src/rx_frame_if.sv
src/uart_cfg_regs.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_cmd_ctrl.sv
src/uart_bridge_top.sv
bench/tb_clk_gen.sv
bench/uart_bridge_sva.sv
bench/tb_uart_bridge.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sources.f --top-module tb_uart_bridge -o tb_sim
	./obj_dir/tb_sim | tee /dev/stderr | grep -q "^Test passed$$"

clean:
	rm -rf obj_dir
